//--- testbench/regex_scan_stimulus.txt
# stream new en_a en_b len payload_hex fired_a fired_b count_a count_b
# fired sampled 3 cycles after eop, counts are running totals; a = "evil", b = "hack"
# single hits, other matcher unchanged
1 1 1 1 12 746865206576696c206f6e65 1 0 1 0
2 1 1 1 7 6861636b657273 0 1 1 1
# repeats and overlapping prefixes count once
3 1 1 1 11 65766576696c206576696c 1 0 2 1
4 1 1 1 5 686861636b 0 1 2 2
# keyword split across two packets of one stream
5 1 1 1 4 78786576 0 0 2 2
5 0 1 1 3 696c21 1 0 3 2
6 1 1 1 5 7a7a686163 0 0 3 2
6 0 1 1 1 6b 0 1 3 3
# split broken by a new stream flag
7 1 1 1 2 6576 0 0 3 3
7 1 1 1 2 696c 0 0 3 3
# split interleaved with another stream
8 1 1 1 5 6162636576 0 0 3 3
9 1 1 1 5 7171686163 0 0 3 3
8 0 1 1 2 696c 1 0 4 3
9 0 1 1 2 6b6b 0 1 4 4
# disabled eop keeps count and stored state
10 1 1 1 2 6576 0 0 4 4
10 0 0 1 5 786576696c 0 0 4 4
10 0 1 1 2 696c 1 0 5 4
11 1 1 1 4 78786861 0 0 5 4
11 0 1 0 2 636b 0 0 5 4
11 0 1 1 2 636b 0 1 5 5
# mixed packets
12 1 1 1 9 6861636b206861636b 0 1 5 6
13 1 1 1 9 6576696c206861636b 1 1 6 7
14 1 1 1 7 65766920686163 0 0 6 7
# old streams resume from their saved state
1 0 1 1 3 76696c 1 0 7 7
14 0 1 1 1 6b 0 1 7 8
# highest stream id
63 1 1 1 6 65766861636b 0 1 7 9
63 0 1 1 2 696c 0 0 7 9

//--- src.f
src/regex_scan_pkg.sv
src/dfa_if.sv
src/keyword_dfa.sv
src/stream_state_store.sv
src/stream_keyword_matcher.sv
src/regex_scan_top.sv
testbench/regex_scan_tb.sv

//--- Bender.yml
package:
  name: regex_scan

dependencies: {}

sources:
  # Package and interface first
  - src/regex_scan_pkg.sv
  - src/dfa_if.sv
  # Design
  - src/keyword_dfa.sv
  - src/stream_state_store.sv
  - src/stream_keyword_matcher.sv
  - src/regex_scan_top.sv
  # Testbench
  - target: test
    files:
      - testbench/regex_scan_tb.sv

//--- testbench/regex_scan_tb.sv
// File-driven testbench for the two-keyword packet scanner
module regex_scan_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string STIM_FILE = "testbench/regex_scan_stimulus.txt";

  // Keywords "evil" and "hack" packed with the first character in the low byte
  localparam logic [119:0] KEY_EVIL = 120'h6c697665;
  localparam logic [119:0] KEY_HACK = 120'h6b636168;

  // Cycles allowed per record beyond its payload
  localparam int RECORD_OVERHEAD = 12;
  localparam int RESET_CYCLES    = 4;

  logic                       clk;
  logic                       rst_n;
  regex_scan_pkg::char_t      char_in;
  logic                       char_in_vld;
  regex_scan_pkg::stream_id_t stream_id;
  logic                       new_stream_id;
  logic                       load_state;
  logic                       eop;
  logic                       enable_a;
  logic                       enable_b;
  logic                       fired_a;
  logic                       fired_b;
  regex_scan_pkg::count_t     count_a;
  regex_scan_pkg::count_t     count_b;

  // One entry per packet record
  int                         rec_sid [$];
  bit                         rec_new [$];
  bit                         rec_en_a [$];
  bit                         rec_en_b [$];
  int                         rec_start [$];
  int                         rec_len [$];
  logic                       rec_fired_a [$];
  logic                       rec_fired_b [$];
  regex_scan_pkg::count_t     rec_count_a [$];
  regex_scan_pkg::count_t     rec_count_b [$];
  // Payload bytes of all records back to back
  regex_scan_pkg::char_t      payload_q [$];

  int                         max_len;
  int                         errors;
  int                         checks;
  int                         watchdog_cycles;
  bit                         loaded;

  regex_scan_top #(
    .KEYWORD_A (KEY_EVIL),
    .KEY_LEN_A (4),
    .KEYWORD_B (KEY_HACK),
    .KEY_LEN_B (4)
  ) dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .stream_id     (stream_id),
    .new_stream_id (new_stream_id),
    .load_state    (load_state),
    .eop           (eop),
    .enable_a      (enable_a),
    .enable_b      (enable_b),
    .fired_a       (fired_a),
    .fired_b       (fired_b),
    .count_a       (count_a),
    .count_b       (count_b)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // Value of one hex digit or -1 for any other character
  function automatic int hex_value(input byte c);
    if (c >= "0" && c <= "9")
      return c - "0";
    if (c >= "a" && c <= "f")
      return c - "a" + 10;
    if (c >= "A" && c <= "F")
      return c - "A" + 10;
    return -1;
  endfunction

  task automatic check_fired(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0d ns: %s fired is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input regex_scan_pkg::count_t got,
                             input regex_scan_pkg::count_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0d ns: %s count is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Parse every record before the run starts
  task automatic read_stimulus(output bit ok);
    int    fd;
    int    n;
    int    line_no;
    int    sid, nw, ea, eb, len, fa, fb, ca, cb;
    int    hi, lo;
    bit    bad_hex;
    string line, tok, hex;
    ok      = 1'b1;
    line_no = 0;
    max_len = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open stimulus file %s", STIM_FILE);
      ok = 1'b0;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      // Blank lines and comment lines carry no record
      if (n > 0 && $sscanf(line, "%s", tok) == 1 && tok.substr(0, 0) != "#")
      begin
        n = $sscanf(line, "%d %d %d %d %d %s %d %d %d %d",
                    sid, nw, ea, eb, len, hex, fa, fb, ca, cb);
        if (n != 10 || len < 1 || hex.len() != 2 * len)
        begin
          $display("ERROR: stimulus line %0d is malformed", line_no);
          ok = 1'b0;
        end
        else
        begin
          bad_hex = 1'b0;
          rec_start.push_back(payload_q.size());
          for (int i = 0; i < len; i++)
          begin
            hi = hex_value(hex[2 * i]);
            lo = hex_value(hex[2 * i + 1]);
            if (hi < 0 || lo < 0)
              bad_hex = 1'b1;
            payload_q.push_back(regex_scan_pkg::char_t'(hi * 16 + lo));
          end
          if (bad_hex)
          begin
            $display("ERROR: stimulus line %0d has a bad hex payload", line_no);
            ok = 1'b0;
          end
          rec_sid.push_back(sid);
          rec_new.push_back(nw != 0);
          rec_en_a.push_back(ea != 0);
          rec_en_b.push_back(eb != 0);
          rec_len.push_back(len);
          rec_fired_a.push_back(fa != 0);
          rec_fired_b.push_back(fb != 0);
          rec_count_a.push_back(regex_scan_pkg::count_t'(ca));
          rec_count_b.push_back(regex_scan_pkg::count_t'(cb));
          if (len > max_len)
            max_len = len;
        end
      end
    end
    $fclose(fd);
    if (rec_sid.size() == 0)
    begin
      $display("ERROR: stimulus file holds no records");
      ok = 1'b0;
    end
  endtask

  // One packet with load, payload, gap, eop and a final sample
  task automatic run_record(input int idx);
    int                         errs_before;
    regex_scan_pkg::stream_id_t sid;
    errs_before = errors;
    sid = regex_scan_pkg::stream_id_t'(rec_sid[idx]);
    @(posedge clk);
    load_state    <= 1'b1;
    stream_id     <= sid;
    new_stream_id <= rec_new[idx];
    enable_a      <= rec_en_a[idx];
    enable_b      <= rec_en_b[idx];
    @(posedge clk);
    load_state    <= 1'b0;
    new_stream_id <= 1'b0;
    // First character lands 2 cycles after the load
    for (int i = 0; i < rec_len[idx]; i++)
    begin
      @(posedge clk);
      char_in     <= payload_q[rec_start[idx] + i];
      char_in_vld <= 1'b1;
    end
    @(posedge clk);
    char_in_vld <= 1'b0;
    // eop 4 cycles after the last character
    repeat (3) @(posedge clk);
    eop <= 1'b1;
    @(posedge clk);
    eop <= 1'b0;
    repeat (3) @(posedge clk);
    // Outputs settle well before the falling edge
    @(negedge clk);
    check_fired($sformatf("record %0d matcher a", idx + 1), fired_a, rec_fired_a[idx]);
    check_fired($sformatf("record %0d matcher b", idx + 1), fired_b, rec_fired_b[idx]);
    check_count($sformatf("record %0d matcher a", idx + 1), count_a, rec_count_a[idx]);
    check_count($sformatf("record %0d matcher b", idx + 1), count_b, rec_count_b[idx]);
    if (errors == errs_before)
      $display("record %0d stream %0d ok", idx + 1, sid);
    else
      $display("record %0d stream %0d mismatch", idx + 1, sid);
  endtask

  initial
  begin : main
    bit load_ok;
    clk           = 1'b0;
    rst_n         = 1'b0;
    char_in       = '0;
    char_in_vld   = 1'b0;
    stream_id     = '0;
    new_stream_id = 1'b0;
    load_state    = 1'b0;
    eop           = 1'b0;
    enable_a      = 1'b0;
    enable_b      = 1'b0;
    errors        = 0;
    checks        = 0;
    loaded        = 1'b0;
    read_stimulus(load_ok);
    if (!load_ok)
    begin
      $display("RESULT: FAIL");
      $finish;
    end
    else
    begin
      // Budget grows with record count and longest payload
      watchdog_cycles = RESET_CYCLES + 4 + rec_sid.size() * (max_len + RECORD_OVERHEAD);
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 0; r < rec_sid.size(); r++)
        run_record(r);
      $display("%0d records, %0d checks, %0d errors", rec_sid.size(), checks, errors);
      if (errors == 0)
        $display("RESULT: PASS");
      else
        $display("RESULT: FAIL");
      $finish;
    end
  end

  // Ends a run that stops making progress
  initial
  begin : watchdog
    wait (loaded);
    repeat (watchdog_cycles) @(posedge clk);
    $display("ERROR: simulation timed out after %0d cycles", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- src/regex_scan_top.sv
// Two keyword matchers scanning a shared interleaved packet stream
module regex_scan_top #(
  // Keyword bytes packed first character in the low byte
  parameter logic [regex_scan_pkg::MAX_KEY_LEN*regex_scan_pkg::CHAR_W-1:0] KEYWORD_A =
    120'h6c697665,
  parameter int KEY_LEN_A = 4,
  parameter logic [regex_scan_pkg::MAX_KEY_LEN*regex_scan_pkg::CHAR_W-1:0] KEYWORD_B =
    120'h6b636168,
  parameter int KEY_LEN_B = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  regex_scan_pkg::char_t      char_in,
  input  logic                       char_in_vld,
  input  regex_scan_pkg::stream_id_t stream_id,
  input  logic                       new_stream_id,
  input  logic                       load_state,
  input  logic                       eop,
  input  logic                       enable_a,
  input  logic                       enable_b,
  output logic                       fired_a,
  output logic                       fired_b,
  output regex_scan_pkg::count_t     count_a,
  output regex_scan_pkg::count_t     count_b
);

  // Matcher for keyword A
  stream_keyword_matcher #(
    .KEYWORD (KEYWORD_A),
    .KEY_LEN (KEY_LEN_A)
  ) matcher_a (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .stream_id     (stream_id),
    .new_stream_id (new_stream_id),
    .load_state    (load_state),
    .eop           (eop),
    .enable        (enable_a),
    .fired         (fired_a),
    .count         (count_a)
  );

  // Matcher for keyword B sees the same packets
  stream_keyword_matcher #(
    .KEYWORD (KEYWORD_B),
    .KEY_LEN (KEY_LEN_B)
  ) matcher_b (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .stream_id     (stream_id),
    .new_stream_id (new_stream_id),
    .load_state    (load_state),
    .eop           (eop),
    .enable        (enable_b),
    .fired         (fired_b),
    .count         (count_b)
  );

endmodule

//--- src/stream_keyword_matcher.sv
// One keyword matcher with per-stream state and packet match counter
module stream_keyword_matcher #(
  parameter logic [regex_scan_pkg::MAX_KEY_LEN*regex_scan_pkg::CHAR_W-1:0] KEYWORD = '0,
  parameter int KEY_LEN = 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  regex_scan_pkg::char_t      char_in,
  input  logic                       char_in_vld,
  input  regex_scan_pkg::stream_id_t stream_id,
  input  logic                       new_stream_id,
  input  logic                       load_state,
  input  logic                       eop,
  input  logic                       enable,
  output logic                       fired,
  output regex_scan_pkg::count_t     count
);

  dfa_if dfa_bus ();

  // Store outputs
  regex_scan_pkg::dfa_state_t restore_state;
  logic                       restore_vld;

  // Registered automaton inputs
  regex_scan_pkg::char_t      char_r;
  logic                       char_vld_r;
  regex_scan_pkg::dfa_state_t state_in_r;
  logic                       state_in_vld_r;

  // Registered automaton state, used for the save at eop
  regex_scan_pkg::dfa_state_t state_out_r;

  logic                       save_en;
  logic                       fired_r;
  regex_scan_pkg::count_t     count_r;

  // Only an enabled matcher keeps its progress across packets
  assign save_en = eop && enable;

  stream_state_store store_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load_state),
    .stream_id     (stream_id),
    .new_stream    (new_stream_id),
    .save          (save_en),
    .save_state    (state_out_r),
    .restore_state (restore_state),
    .restore_vld   (restore_vld)
  );

  // Strobes toward the automaton
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r     <= 1'b0;
      state_in_vld_r <= 1'b0;
    end
    else
    begin
      char_vld_r     <= char_in_vld;
      state_in_vld_r <= restore_vld;
    end
  end

  // Data paths around the automaton
  always_ff @(posedge clk)
  begin
    char_r      <= char_in;
    state_in_r  <= restore_state;
    state_out_r <= dfa_bus.state_out;
  end

  assign dfa_bus.char_in      = char_r;
  assign dfa_bus.char_vld     = char_vld_r;
  assign dfa_bus.state_in     = state_in_r;
  assign dfa_bus.state_in_vld = state_in_vld_r;

  keyword_dfa #(
    .KEYWORD (KEYWORD),
    .KEY_LEN (KEY_LEN)
  ) dfa_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (dfa_bus.dfa)
  );

  // Fired flag and packet count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired_r <= 1'b0;
      count_r <= '0;
    end
    else
    begin
      // New packet starts unfired
      if (load_state)
        fired_r <= 1'b0;
      // Any hit marks the packet and later hits change nothing
      if (dfa_bus.accept)
        fired_r <= 1'b1;
      if (eop)
      begin
        if (enable)
          count_r <= count_r + regex_scan_pkg::count_t'(fired_r);
        else
          // Disabled packet leaves no trace
          fired_r <= 1'b0;
      end
    end
  end

  assign fired = fired_r;
  assign count = count_r;

endmodule

//--- src/stream_state_store.sv
// Per-stream automaton state memory
module stream_state_store (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load,
  input  regex_scan_pkg::stream_id_t stream_id,
  input  logic                       new_stream,
  input  logic                       save,
  input  regex_scan_pkg::dfa_state_t save_state,
  output regex_scan_pkg::dfa_state_t restore_state,
  output logic                       restore_vld
);

  // One saved automaton state per stream
  regex_scan_pkg::dfa_state_t state_mem [regex_scan_pkg::NUM_STREAMS];

  // Write back the state reached at end of packet
  always_ff @(posedge clk)
  begin
    if (save)
      state_mem[stream_id] <= save_state;
  end

  // Restore value for the packet about to start
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      // Fresh stream starts with nothing matched
      if (new_stream)
        restore_state <= '0;
      else
        restore_state <= state_mem[stream_id];
    end
  end

  // Restore strobe follows load by one cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      restore_vld <= 1'b0;
    else
      restore_vld <= load;
  end

endmodule

//--- src/keyword_dfa.sv
// Literal keyword automaton with prefix fallback
module keyword_dfa #(
  parameter logic [regex_scan_pkg::MAX_KEY_LEN*regex_scan_pkg::CHAR_W-1:0] KEYWORD = '0,
  parameter int KEY_LEN = 1
) (
  input logic clk,
  input logic rst_n,
  dfa_if.dfa  bus
);

  localparam int CW = regex_scan_pkg::CHAR_W;

  // Longest proper prefix of the keyword that is also its suffix
  function automatic int full_border();
    int   best_len;
    logic same;
    best_len = 0;
    for (int len = 1; len < KEY_LEN; len++)
    begin
      same = 1'b1;
      for (int j = 0; j < len; j++)
      begin
        if (KEYWORD[j*CW +: CW] != KEYWORD[(KEY_LEN-len+j)*CW +: CW])
          same = 1'b0;
      end
      if (same)
        best_len = len;
    end
    return best_len;
  endfunction

  // State to continue from after a full match so overlapping hits survive
  localparam regex_scan_pkg::dfa_state_t RESUME = regex_scan_pkg::dfa_state_t'(full_border());

  regex_scan_pkg::dfa_state_t cur_state;
  regex_scan_pkg::dfa_state_t base_state;
  regex_scan_pkg::dfa_state_t next_len;
  logic                       hit;
  logic                       accept_r;

  // Next matched length for the incoming character
  always_comb
  begin : next_state_calc
    int   start;
    logic ok;
    // A restore in the same cycle takes the place of the held state
    base_state = bus.state_in_vld ? bus.state_in : cur_state;
    next_len   = '0;
    // Try every candidate length and keep the longest that fits
    for (int len = 1; len <= KEY_LEN; len++)
    begin
      // Candidate must end with the new character
      ok = (len <= int'(base_state) + 1) &&
           (KEYWORD[(len-1)*CW +: CW] == bus.char_in);
      // Text before the character is keyword[0 .. base-1]
      // so its tail of len-1 bytes begins here
      start = int'(base_state) + 1 - len;
      for (int j = 0; j < len - 1; j++)
      begin
        if (ok && (KEYWORD[j*CW +: CW] != KEYWORD[(start+j)*CW +: CW]))
          ok = 1'b0;
      end
      if (ok)
        next_len = regex_scan_pkg::dfa_state_t'(len);
    end
    // Whole keyword seen
    hit = (int'(next_len) == KEY_LEN);
  end

  // State and accept update on each consumed character
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cur_state <= '0;
      accept_r  <= 1'b0;
    end
    else if (bus.char_vld)
    begin
      cur_state <= hit ? RESUME : next_len;
      accept_r  <= hit;
    end
    else
    begin
      // Accept is a single-cycle pulse
      accept_r <= 1'b0;
      if (bus.state_in_vld)
        cur_state <= bus.state_in;
    end
  end

  assign bus.state_out = cur_state;
  assign bus.accept    = accept_r;

endmodule

//--- src/dfa_if.sv
// Character and state path between a matcher wrapper and its automaton
interface dfa_if;

  // Character to consume, qualified by a one-cycle strobe
  regex_scan_pkg::char_t      char_in;
  logic                       char_vld;

  // State overwrite from the per-stream store
  // Loaded state wins when both strobes arrive together
  regex_scan_pkg::dfa_state_t state_in;
  logic                       state_in_vld;

  // Registered automaton outputs
  regex_scan_pkg::dfa_state_t state_out;
  logic                       accept;

  // Wrapper side
  modport matcher (
    output char_in,
    output char_vld,
    output state_in,
    output state_in_vld,
    input  state_out,
    input  accept
  );

  // Automaton side
  modport dfa (
    input  char_in,
    input  char_vld,
    input  state_in,
    input  state_in_vld,
    output state_out,
    output accept
  );

endinterface

//--- src/regex_scan_pkg.sv
// Shared widths and types for the multi-stream keyword scanner
package regex_scan_pkg;

  // One payload character per cycle
  localparam int CHAR_W = 8;

  // Payload byte as seen by the matchers
  typedef logic [CHAR_W-1:0] char_t;

  // Stream ids come from the packet classifier outside the design
  localparam int STREAM_ID_W = 6;

  // Depth of the per-stream state memory
  localparam int NUM_STREAMS = 1 << STREAM_ID_W;

  typedef logic [STREAM_ID_W-1:0] stream_id_t;

  // Automaton state is the matched prefix length
  localparam int STATE_W = 4;

  // Number of keyword characters matched so far
  typedef logic [STATE_W-1:0] dfa_state_t;

  // Longest keyword whose full length still fits in the state
  localparam int MAX_KEY_LEN = (1 << STATE_W) - 1;

  // Packet match counters wrap at this width
  localparam int COUNT_W = 16;

  typedef logic [COUNT_W-1:0] count_t;

endpackage
